// ==== include/div_defs.svh ====
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// Operand and result width
`define DIV_XLEN 64

// Width of the word ops
`define DIV_WLEN 32

// Iteration counter and its start values
`define DIV_CNT_W 7
`define DIV_ITER_D 7'd64
`define DIV_ITER_W 7'd32

`endif

// ==== hdl/div_pkg.sv ====
`default_nettype none

package div_pkg;

    // Divide opcodes, signed ones first in each pair
    typedef enum logic [2:0] {
        DIV   = 3'd0,
        DIVU  = 3'd1,
        REM   = 3'd2,
        REMU  = 3'd3,
        DIVW  = 3'd4,
        DIVUW = 3'd5,
        REMW  = 3'd6,
        REMUW = 3'd7
    } div_op_e;

    // Iterative core states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        ITER = 2'd2,
        HAND = 2'd3
    } div_state_e;

endpackage

`default_nettype wire

// ==== hdl/div_operand_prep.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "div_defs.svh"

module div_operand_prep (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  div_pkg::div_op_e     op,
    input  logic [`DIV_XLEN-1:0] dividend,
    input  logic [`DIV_XLEN-1:0] divisor,
    output logic                 prep_valid,
    output div_pkg::div_op_e     op_q,
    output logic [`DIV_XLEN-1:0] abs_dividend,
    output logic [`DIV_XLEN-1:0] abs_divisor,
    output logic                 is_word,
    output logic                 neg_quot,
    output logic                 neg_rem,
    output logic                 div_zero,
    output logic                 overflow,
    output logic [`DIV_XLEN-1:0] orig_dividend
);

    import div_pkg::*;

    logic                 op_signed;
    logic                 op_word;
    logic [`DIV_XLEN-1:0] ext_dividend;
    logic [`DIV_XLEN-1:0] ext_divisor;
    logic                 sign_a;
    logic                 sign_b;
    logic [`DIV_XLEN-1:0] most_neg;

    assign op_signed = op inside {DIV, REM, DIVW, REMW};
    assign op_word   = op inside {DIVW, DIVUW, REMW, REMUW};

    // Word ops see only the low half, extended by signedness
    always_comb begin
        if (op_word) begin
            ext_dividend = {{(`DIV_XLEN-`DIV_WLEN){op_signed & dividend[`DIV_WLEN-1]}},
                            dividend[`DIV_WLEN-1:0]};
            ext_divisor  = {{(`DIV_XLEN-`DIV_WLEN){op_signed & divisor[`DIV_WLEN-1]}},
                            divisor[`DIV_WLEN-1:0]};
            most_neg     = {{(`DIV_XLEN-`DIV_WLEN+1){1'b1}}, {(`DIV_WLEN-1){1'b0}}};
        end else begin
            ext_dividend = dividend;
            ext_divisor  = divisor;
            most_neg     = {1'b1, {(`DIV_XLEN-1){1'b0}}};
        end
    end

    assign sign_a = op_signed & ext_dividend[`DIV_XLEN-1];
    assign sign_b = op_signed & ext_divisor[`DIV_XLEN-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prep_valid <= 1'b0;
        end else begin
            prep_valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q          <= op;
            abs_dividend  <= sign_a ? -ext_dividend : ext_dividend;
            abs_divisor   <= sign_b ? -ext_divisor : ext_divisor;
            is_word       <= op_word;
            neg_quot      <= sign_a ^ sign_b;
            neg_rem       <= sign_a;
            div_zero      <= (ext_divisor == '0);
            // Most negative value over minus one, at the op's width
            overflow      <= op_signed && (ext_dividend == most_neg) && (&ext_divisor);
            orig_dividend <= ext_dividend;
        end
    end

    a_special_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        prep_valid |-> !(div_zero && overflow)
    );

endmodule

`default_nettype wire

// ==== hdl/div_iter_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "div_defs.svh"

module div_iter_core (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 prep_valid,
    input  div_pkg::div_op_e     op_q,
    input  logic [`DIV_XLEN-1:0] abs_dividend,
    input  logic [`DIV_XLEN-1:0] abs_divisor,
    input  logic                 is_word,
    input  logic                 neg_quot,
    input  logic                 neg_rem,
    input  logic                 div_zero,
    input  logic                 overflow,
    input  logic [`DIV_XLEN-1:0] orig_dividend,
    output logic                 core_done,
    output logic [`DIV_XLEN-1:0] quot_mag,
    output logic [`DIV_XLEN-1:0] rem_mag,
    output div_pkg::div_op_e     op_c,
    output logic                 neg_quot_c,
    output logic                 neg_rem_c,
    output logic                 div_zero_c,
    output logic                 overflow_c,
    output logic [`DIV_XLEN-1:0] orig_dividend_c
);

    import div_pkg::*;

    localparam logic [`DIV_CNT_W-1:0] CNT_ONE = 'd1;

    div_state_e               state;
    logic [`DIV_CNT_W-1:0]    iter_cnt;
    logic                     load_en;
    logic                     iter_en;
    logic [2*`DIV_XLEN-1:0]   part_rem;
    logic [2*`DIV_XLEN-1:0]   cmp_op;
    logic [2*`DIV_XLEN:0]     rem_sh;
    logic [2*`DIV_XLEN:0]     rem_diff;
    logic                     rem_ge;

    assign load_en = (state == IDLE) && prep_valid;
    assign iter_en = (state == LOAD) || (state == ITER);

    // One extra bit keeps the shifted-out MSB for large divisors
    assign rem_sh   = {part_rem, 1'b0};
    assign rem_diff = rem_sh - {1'b0, cmp_op};
    assign rem_ge   = rem_sh >= {1'b0, cmp_op};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            iter_cnt <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (prep_valid) begin
                        state    <= LOAD;
                        iter_cnt <= is_word ? `DIV_ITER_W : `DIV_ITER_D;
                    end
                end
                LOAD, ITER: begin
                    iter_cnt <= iter_cnt - CNT_ONE;
                    state    <= (iter_cnt == CNT_ONE) ? HAND : ITER;
                end
                HAND: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            // Word dividend sits pre-shifted so 32 steps are enough
            if (is_word) begin
                part_rem <= {{`DIV_XLEN{1'b0}}, abs_dividend[`DIV_WLEN-1:0],
                             {`DIV_WLEN{1'b0}}};
            end else begin
                part_rem <= {{`DIV_XLEN{1'b0}}, abs_dividend};
            end
            cmp_op <= {abs_divisor, {`DIV_XLEN{1'b0}}};
        end else if (iter_en) begin
            if (rem_ge) begin
                part_rem <= {rem_diff[2*`DIV_XLEN-1:1], 1'b1};
            end else begin
                part_rem <= rem_sh[2*`DIV_XLEN-1:0];
            end
        end
    end

    // Fields for the fix-up stage
    always_ff @(posedge clk) begin
        if (load_en) begin
            op_c            <= op_q;
            neg_quot_c      <= neg_quot;
            neg_rem_c       <= neg_rem;
            div_zero_c      <= div_zero;
            overflow_c      <= overflow;
            orig_dividend_c <= orig_dividend;
        end
    end

    assign core_done = (state == HAND);
    assign quot_mag  = part_rem[`DIV_XLEN-1:0];
    assign rem_mag   = part_rem[2*`DIV_XLEN-1:`DIV_XLEN];

    a_prep_in_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        prep_valid |-> state == IDLE
    );

    a_done_single: assert property (
        @(posedge clk) disable iff (!arst_n)
        core_done |=> !core_done
    );

endmodule

`default_nettype wire

// ==== hdl/div_result_fix.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "div_defs.svh"

module div_result_fix (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 core_done,
    input  div_pkg::div_op_e     op_c,
    input  logic [`DIV_XLEN-1:0] quot_mag,
    input  logic [`DIV_XLEN-1:0] rem_mag,
    input  logic                 neg_quot_c,
    input  logic                 neg_rem_c,
    input  logic                 div_zero_c,
    input  logic                 overflow_c,
    input  logic [`DIV_XLEN-1:0] orig_dividend_c,
    output logic [`DIV_XLEN-1:0] result,
    output logic                 done
);

    import div_pkg::*;

    logic                 op_rem;
    logic                 op_word;
    logic [`DIV_XLEN-1:0] quot_s;
    logic [`DIV_XLEN-1:0] rem_s;
    logic [`DIV_XLEN-1:0] quot_f;
    logic [`DIV_XLEN-1:0] rem_f;
    logic [`DIV_XLEN-1:0] sel;
    logic [`DIV_XLEN-1:0] res_next;

    assign op_rem  = op_c inside {REM, REMU, REMW, REMUW};
    assign op_word = op_c inside {DIVW, DIVUW, REMW, REMUW};

    assign quot_s = neg_quot_c ? -quot_mag : quot_mag;
    assign rem_s  = neg_rem_c ? -rem_mag : rem_mag;

    // RISC-V special values replace the iterated ones
    always_comb begin
        if (div_zero_c) begin
            quot_f = '1;
            rem_f  = orig_dividend_c;
        end else if (overflow_c) begin
            quot_f = orig_dividend_c;
            rem_f  = '0;
        end else begin
            quot_f = quot_s;
            rem_f  = rem_s;
        end
    end

    assign sel = op_rem ? rem_f : quot_f;

    // Word results are sign-extended from bit 31
    assign res_next = op_word ? {{(`DIV_XLEN-`DIV_WLEN){sel[`DIV_WLEN-1]}},
                                 sel[`DIV_WLEN-1:0]}
                              : sel;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= core_done;
            if (core_done) begin
                result <= res_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/div_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "div_defs.svh"

module div_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  div_pkg::div_op_e     op,
    input  logic [`DIV_XLEN-1:0] dividend,
    input  logic [`DIV_XLEN-1:0] divisor,
    output logic                 busy,
    output logic [`DIV_XLEN-1:0] result,
    output logic                 done
);

    import div_pkg::*;

    logic                 prep_valid;
    div_op_e              op_q;
    logic [`DIV_XLEN-1:0] abs_dividend;
    logic [`DIV_XLEN-1:0] abs_divisor;
    logic                 is_word;
    logic                 neg_quot;
    logic                 neg_rem;
    logic                 div_zero;
    logic                 overflow;
    logic [`DIV_XLEN-1:0] orig_dividend;

    logic                 core_done;
    logic [`DIV_XLEN-1:0] quot_mag;
    logic [`DIV_XLEN-1:0] rem_mag;
    div_op_e              op_c;
    logic                 neg_quot_c;
    logic                 neg_rem_c;
    logic                 div_zero_c;
    logic                 overflow_c;
    logic [`DIV_XLEN-1:0] orig_dividend_c;

    // Drops on the edge that raises done, so the done cycle can take a new start
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (core_done) begin
            busy <= 1'b0;
        end
    end

    div_operand_prep prep_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .start         (start),
        .op            (op),
        .dividend      (dividend),
        .divisor       (divisor),
        .prep_valid    (prep_valid),
        .op_q          (op_q),
        .abs_dividend  (abs_dividend),
        .abs_divisor   (abs_divisor),
        .is_word       (is_word),
        .neg_quot      (neg_quot),
        .neg_rem       (neg_rem),
        .div_zero      (div_zero),
        .overflow      (overflow),
        .orig_dividend (orig_dividend)
    );

    div_iter_core core_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .prep_valid      (prep_valid),
        .op_q            (op_q),
        .abs_dividend    (abs_dividend),
        .abs_divisor     (abs_divisor),
        .is_word         (is_word),
        .neg_quot        (neg_quot),
        .neg_rem         (neg_rem),
        .div_zero        (div_zero),
        .overflow        (overflow),
        .orig_dividend   (orig_dividend),
        .core_done       (core_done),
        .quot_mag        (quot_mag),
        .rem_mag         (rem_mag),
        .op_c            (op_c),
        .neg_quot_c      (neg_quot_c),
        .neg_rem_c       (neg_rem_c),
        .div_zero_c      (div_zero_c),
        .overflow_c      (overflow_c),
        .orig_dividend_c (orig_dividend_c)
    );

    div_result_fix fix_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .core_done       (core_done),
        .op_c            (op_c),
        .quot_mag        (quot_mag),
        .rem_mag         (rem_mag),
        .neg_quot_c      (neg_quot_c),
        .neg_rem_c       (neg_rem_c),
        .div_zero_c      (div_zero_c),
        .overflow_c      (overflow_c),
        .orig_dividend_c (orig_dividend_c),
        .result          (result),
        .done            (done)
    );

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        start |-> !busy
    );

endmodule

`default_nettype wire

// ==== verification/clk_rst_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_rst_gen (
    output logic clk,
    output logic arst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Reset covers the first 4 rising edges, released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/div_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "div_defs.svh"

module div_unit_tb;

    import div_pkg::*;

    localparam int TIMEOUT = 100;

    logic                 clk;
    logic                 arst_n;
    logic                 start;
    div_op_e              op;
    logic [`DIV_XLEN-1:0] dividend;
    logic [`DIV_XLEN-1:0] divisor;
    logic                 busy;
    logic [`DIV_XLEN-1:0] result;
    logic                 done;

    int   data_errors   = 0;
    int   timing_errors = 0;
    int   flag_errors   = 0;
    int   other_errors  = 0;
    logic timed_out     = 1'b0;

    clk_rst_gen clk_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    div_unit div_unit_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .busy     (busy),
        .result   (result),
        .done     (done)
    );

    function automatic logic [`DIV_XLEN-1:0] sext_word(input logic [`DIV_XLEN-1:0] v);
        return {{32{v[31]}}, v[31:0]};
    endfunction

    // Reference model of the RISC-V M divide rules
    function automatic logic [`DIV_XLEN-1:0] expected_result(input div_op_e o,
            input logic [`DIV_XLEN-1:0] a, input logic [`DIV_XLEN-1:0] b);
        logic                 sgn;
        logic                 word;
        logic [`DIV_XLEN-1:0] x;
        logic [`DIV_XLEN-1:0] y;
        logic [`DIV_XLEN-1:0] q;
        logic [`DIV_XLEN-1:0] r;
        logic [`DIV_XLEN-1:0] min_val;
        logic [`DIV_XLEN-1:0] res;
        sgn     = o inside {DIV, REM, DIVW, REMW};
        word    = o inside {DIVW, DIVUW, REMW, REMUW};
        x       = a;
        y       = b;
        min_val = 64'h8000_0000_0000_0000;
        if (word) begin
            x       = sgn ? sext_word(a) : {32'h0, a[31:0]};
            y       = sgn ? sext_word(b) : {32'h0, b[31:0]};
            min_val = sext_word(64'h8000_0000);
        end
        if (y == '0) begin
            q = '1;
            r = x;
        end else if (sgn && x == min_val && y == '1) begin
            q = x;
            r = '0;
        end else if (sgn) begin
            q = $signed(x) / $signed(y);
            r = $signed(x) % $signed(y);
        end else begin
            q = x / y;
            r = x % y;
        end
        res = (o inside {REM, REMU, REMW, REMUW}) ? r : q;
        return word ? sext_word(res) : res;
    endfunction

    task automatic compare_data(input string name, input logic [`DIV_XLEN-1:0] got,
                                input logic [`DIV_XLEN-1:0] want);
        if (got !== want) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
            data_errors++;
        end
    endtask

    task automatic compare_op_timing(input div_op_e o, input int cycles);
        int want;
        if (o inside {DIVW, DIVUW, REMW, REMUW}) begin
            want = int'(`DIV_ITER_W) + 2;
        end else begin
            want = int'(`DIV_ITER_D) + 2;
        end
        if (cycles != want) begin
            $display("FAILED latency %s: got 0x%h, expected 0x%h", o.name(), cycles, want);
            timing_errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
            flag_errors++;
        end
    endtask

    // Entered on a falling edge, returns on the falling edge inside the done cycle
    task automatic run_op(input div_op_e o, input logic [`DIV_XLEN-1:0] a,
                          input logic [`DIV_XLEN-1:0] b,
                          output logic [`DIV_XLEN-1:0] res, output int cycles);
        logic busy_ok;
        busy_ok = 1'b1;
        res     = '0;
        cycles  = 0;
        if (!timed_out) begin
            op       = o;
            dividend = a;
            divisor  = b;
            start    = 1'b1;
            @(negedge clk);
            start = 1'b0;
            while (!done && cycles < TIMEOUT) begin
                busy_ok = busy_ok & busy;
                @(negedge clk);
                cycles++;
            end
            if (!done) begin
                $display("Timeout: %s gave no done within %0d cycles", o.name(), TIMEOUT);
                timed_out = 1'b1;
                other_errors++;
            end else begin
                res = result;
                compare_flag("busy while running", busy_ok, 1'b1);
                compare_flag("busy in done cycle", busy, 1'b0);
            end
        end
    endtask

    task automatic check_op(input div_op_e o, input logic [`DIV_XLEN-1:0] a,
                            input logic [`DIV_XLEN-1:0] b);
        logic [`DIV_XLEN-1:0] res;
        int                   cycles;
        run_op(o, a, b, res, cycles);
        if (!timed_out) begin
            compare_data($sformatf("result %s a=%h b=%h", o.name(), a, b), res,
                         expected_result(o, a, b));
            compare_op_timing(o, cycles);
        end
    endtask

    task automatic test_reset_state();
        compare_flag("busy", busy, 1'b0);
        compare_flag("done", done, 1'b0);
        compare_data("result", result, '0);
    endtask

    task automatic test_doubleword_ops();
        check_op(DIV, 64'd20, 64'd6);
        check_op(DIV, -64'd20, 64'd6);
        check_op(DIV, 64'd20, -64'd6);
        check_op(DIV, -64'd20, -64'd6);
        check_op(REM, -64'd20, 64'd6);
        check_op(REM, 64'd20, -64'd6);
        check_op(REM, -64'd20, -64'd6);
        check_op(DIVU, 64'hFFFF_FFFF_FFFF_FFFF, 64'd3);
        check_op(DIVU, 64'hFFFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0001);
        check_op(REMU, 64'hFFFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0001);
        check_op(REMU, 64'h0123_4567_89AB_CDEF, 64'h0000_0000_0001_0000);
        check_op(DIVU, 64'd1, 64'hFFFF_FFFF_FFFF_FFFE);
    endtask

    // Upper halves carry junk that word ops must ignore
    task automatic test_word_ops();
        check_op(DIVW, 64'hDEAD_BEEF_0000_0014, 64'h1234_5678_FFFF_FFFA);
        check_op(DIVUW, 64'hFFFF_FFFF_8000_0000, 64'h0000_0001_0000_0002);
        check_op(DIVUW, 64'h5555_5555_FFFF_FFFF, 64'hAAAA_AAAA_0000_0001);
        check_op(REMW, 64'h0000_0000_FFFF_FFF9, 64'hFFFF_0000_0000_0002);
        check_op(REMUW, 64'h7777_7777_FFFF_FFF9, 64'h0000_0001_0000_0010);
        check_op(REMW, 64'h0000_0001_7FFF_FFFF, 64'h0000_0000_FFFF_FF00);
    endtask

    task automatic test_special_cases();
        check_op(DIV, 64'h8765_4321_0FED_CBA9, 64'd0);
        check_op(DIVU, 64'h8765_4321_0FED_CBA9, 64'd0);
        check_op(REM, 64'h8765_4321_0FED_CBA9, 64'd0);
        check_op(REMU, 64'h8765_4321_0FED_CBA9, 64'd0);
        check_op(DIVW, 64'h1111_1111_8000_0123, 64'hFFFF_FFFF_0000_0000);
        check_op(DIVUW, 64'h1111_1111_8000_0123, 64'hFFFF_FFFF_0000_0000);
        check_op(REMW, 64'h1111_1111_8000_0123, 64'hFFFF_FFFF_0000_0000);
        check_op(REMUW, 64'h1111_1111_8000_0123, 64'hFFFF_FFFF_0000_0000);
        check_op(DIV, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);
        check_op(REM, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);
        check_op(DIVU, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);
        check_op(DIVW, 64'h0000_0000_8000_0000, 64'h0000_0000_FFFF_FFFF);
        check_op(REMW, 64'h0000_0000_8000_0000, 64'h0000_0000_FFFF_FFFF);
    endtask

    // Each start lands in the done cycle of the op before
    task automatic test_latency_back_to_back();
        for (int i = 0; i < 8; i++) begin
            check_op(div_op_e'(3'(i)), 64'h0FED_CBA9_8765_4321 + 64'(i), 64'd7 + 64'(i));
        end
        @(negedge clk);
        compare_flag("done after pulse", done, 1'b0);
        compare_flag("busy when idle", busy, 1'b0);
    endtask

    task automatic test_random_ops();
        int                   sel;
        int                   kind;
        logic [`DIV_XLEN-1:0] a;
        logic [`DIV_XLEN-1:0] b;
        for (int i = 0; i < 200; i++) begin
            sel  = $urandom_range(7, 0);
            kind = $urandom_range(7, 0);
            a    = {$urandom, $urandom};
            b    = {$urandom, $urandom};
            if (kind == 0) begin
                b = '0;
            end else if (kind == 1) begin
                b = 64'($urandom_range(9, 1));
            end else if (kind == 2) begin
                b = -64'($urandom_range(9, 1));
            end
            check_op(div_op_e'(sel[2:0]), a, b);
        end
    endtask

    initial begin
        int n;
        start    = 1'b0;
        op       = DIV;
        dividend = '0;
        divisor  = '0;
        void'($urandom(43));
        n        = 0;
        while (arst_n !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            $display("Reset was never released");
            other_errors++;
        end
        @(negedge clk);
        test_reset_state();
        test_doubleword_ops();
        test_word_ops();
        test_special_cases();
        test_latency_back_to_back();
        test_random_ops();
        $display("Errors: data %0d, timing %0d, flags %0d, other %0d",
                 data_errors, timing_errors, flag_errors, other_errors);
        if (data_errors + timing_errors + flag_errors + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
hdl/div_pkg.sv
hdl/div_operand_prep.sv
hdl/div_iter_core.sv
hdl/div_result_fix.sv
hdl/div_unit.sv
verification/clk_rst_gen.sv
verification/div_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the divider testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module div_unit_tb -o div_unit_tb_sim \
    && ./obj_dir/div_unit_tb_sim | tee /dev/stderr | grep -q "sim passed" \
    && echo "Simulation OK" \
    || { echo "Simulation FAILED"; exit 1; }
